// ==== common/bgs_pkg.sv ====
package bgs_pkg;

  // Frame geometry
  localparam int FRAME_W = 64;
  localparam int FRAME_H = 48;
  localparam int X_W     = 6;
  localparam int Y_W     = 6;

  typedef logic [15:0] rgb565_t;  // R5 G6 B5

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb888_t;

  typedef struct packed {
    logic [X_W-1:0] x;
    logic [Y_W-1:0] y;
  } coord_t;

  typedef enum logic [1:0] {
    CLS_BG        = 2'd0,
    CLS_FG        = 2'd1,
    CLS_SHADOW    = 2'd2,
    CLS_HIGHLIGHT = 2'd3
  } px_class_e;

  localparam rgb565_t COLOR_BG        = 16'h07E0;  // Green
  localparam rgb565_t COLOR_FG        = 16'hF800;  // Red
  localparam rgb565_t COLOR_SHADOW    = 16'h001F;  // Blue
  localparam rgb565_t COLOR_HIGHLIGHT = 16'hFFE0;  // Yellow

  // Brightness ratio bounds in sixteenths
  localparam int ALPHA_LO_Q4  = 8;
  localparam int SHADOW_Q4    = 14;
  localparam int HIGHLIGHT_Q4 = 18;
  localparam int ALPHA_HI_Q4  = 24;
  localparam int CD_Q4        = 1;   // Sine squared bound
  localparam int LEARN_SHIFT  = 2;   // Model moves 1/4 of the way per update

  typedef struct packed {
    coord_t  xy;
    rgb888_t i;
    rgb888_t e;
  } pix_model_t;

  typedef struct packed {
    coord_t      xy;
    rgb888_t     i;
    rgb888_t     e;
    logic [17:0] ie;
    logic [17:0] ee;
    logic [17:0] ii;
    logic [35:0] cross2;  // |I x E| squared
  } dist_terms_t;

endpackage

// ==== common/mem_pkg.sv ====
package mem_pkg;

  localparam int MODEL_DEPTH = bgs_pkg::FRAME_W * bgs_pkg::FRAME_H;
  localparam int MODEL_AW    = 12;

  typedef logic [MODEL_AW-1:0] model_addr_t;
  typedef bgs_pkg::rgb888_t    model_entry_t;

  typedef struct packed {
    logic         valid;
    model_addr_t  addr;
    model_entry_t entry;
  } model_wr_t;

  // Which side owns the RAM port this cycle
  typedef enum logic {
    REQ_READ  = 1'b0,
    REQ_WRITE = 1'b1
  } requester_e;

  // Raster index of a pixel
  function automatic model_addr_t xy_to_addr(bgs_pkg::coord_t xy);
    return model_addr_t'(xy.y * bgs_pkg::FRAME_W + xy.x);
  endfunction

endpackage

// ==== src/pixel_ingest.sv ====
module pixel_ingest (
  input  logic                  clk_pixel,
  input  logic                  sys_rst_pixel,
  input  logic                  pix_valid_i,
  input  bgs_pkg::rgb565_t      pix_i,
  input  bgs_pkg::coord_t       pix_xy_i,
  output logic                  rd_en_o,
  output mem_pkg::model_addr_t  rd_addr_o,
  input  mem_pkg::model_entry_t rd_entry_i,
  output logic                  pm_valid_o,
  output bgs_pkg::pix_model_t   pm_o
);

  bgs_pkg::rgb888_t pix_exp;
  bgs_pkg::rgb888_t pix_q;
  bgs_pkg::coord_t  xy_q;
  logic             pix_valid_q;

  // Zero fill the low bits of each channel
  assign pix_exp.r = {pix_i[15:11], 3'b000};
  assign pix_exp.g = {pix_i[10:5], 2'b00};
  assign pix_exp.b = {pix_i[4:0], 3'b000};

  // Read goes out in the same cycle, estimate is back one cycle later
  assign rd_en_o   = pix_valid_i;
  assign rd_addr_o = mem_pkg::xy_to_addr(pix_xy_i);

  always_ff @(posedge clk_pixel or posedge sys_rst_pixel) begin
    if (sys_rst_pixel) begin
      pix_valid_q <= 1'b0;
      pm_valid_o  <= 1'b0;
    end else begin
      pix_valid_q <= pix_valid_i;
      pm_valid_o  <= pix_valid_q;
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (pix_valid_i) begin
      pix_q <= pix_exp;
      xy_q  <= pix_xy_i;
    end
    pm_o.xy <= xy_q;
    pm_o.i  <= pix_q;
    pm_o.e  <= rd_entry_i;  // Lines up with pix_q
  end

  // Free cycle after every pixel is what lets a held write through
  a_pix_spacing: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
    pix_valid_i |=> !pix_valid_i)
    else $error("pix_valid_i high in two adjacent cycles");

endmodule

// ==== model/model_store.sv ====
module model_store (
  input  logic                  clk_pixel,
  input  logic                  sys_rst_pixel,
  input  logic                  rd_en_i,
  input  mem_pkg::model_addr_t  rd_addr_i,
  output mem_pkg::model_entry_t rd_entry_o,
  input  mem_pkg::model_wr_t    wr_i
);

  mem_pkg::model_entry_t ram [mem_pkg::MODEL_DEPTH] = '{default: '0};
  mem_pkg::requester_e   grant;
  logic                  held_valid_q;
  mem_pkg::model_addr_t  held_addr_q;
  mem_pkg::model_entry_t held_entry_q;
  logic                  wr_go;
  mem_pkg::model_addr_t  wr_addr;
  mem_pkg::model_entry_t wr_entry;

  assign grant = rd_en_i ? mem_pkg::REQ_READ : mem_pkg::REQ_WRITE;  // Read wins a tie

  // Held write drains ahead of anything new
  assign wr_go    = (grant == mem_pkg::REQ_WRITE) && (held_valid_q || wr_i.valid);
  assign wr_addr  = held_valid_q ? held_addr_q : wr_i.addr;
  assign wr_entry = held_valid_q ? held_entry_q : wr_i.entry;

  always_ff @(posedge clk_pixel) begin
    if (grant == mem_pkg::REQ_READ) begin
      rd_entry_o <= ram[rd_addr_i];
    end else if (wr_go) begin
      ram[wr_addr] <= wr_entry;
    end
  end

  always_ff @(posedge clk_pixel or posedge sys_rst_pixel) begin
    if (sys_rst_pixel) begin
      held_valid_q <= 1'b0;
    end else if (grant == mem_pkg::REQ_READ) begin
      held_valid_q <= held_valid_q || wr_i.valid;
    end else begin
      held_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (grant == mem_pkg::REQ_READ && wr_i.valid) begin
      held_addr_q  <= wr_i.addr;
      held_entry_q <= wr_i.entry;
    end
  end

  a_held_once: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
    held_valid_q |=> !held_valid_q)
    else $error("held model write waited a second cycle");

  a_no_overrun: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
    held_valid_q |-> !wr_i.valid)
    else $error("new model write while one is held");

endmodule

// ==== classify/distortion_calc.sv ====
module distortion_calc (
  input  logic                 clk_pixel,
  input  logic                 sys_rst_pixel,
  input  logic                 pm_valid_i,
  input  bgs_pkg::pix_model_t  pm_i,
  output logic                 dt_valid_o,
  output bgs_pkg::dist_terms_t dt_o
);

  logic                [2:0][15:0] ie_p;  // Index 2 is red
  logic                [2:0][15:0] ee_p;
  logic                [2:0][15:0] ii_p;
  logic signed         [16:0]      cx_q;
  logic signed         [16:0]      cy_q;
  logic signed         [16:0]      cz_q;
  bgs_pkg::pix_model_t             s1_q;
  logic                            s1_valid_q;

  always_ff @(posedge clk_pixel or posedge sys_rst_pixel) begin
    if (sys_rst_pixel) begin
      s1_valid_q <= 1'b0;
      dt_valid_o <= 1'b0;
    end else begin
      s1_valid_q <= pm_valid_i;
      dt_valid_o <= s1_valid_q;
    end
  end

  // Stage one, per-channel products
  always_ff @(posedge clk_pixel) begin
    s1_q    <= pm_i;
    ie_p[2] <= pm_i.i.r * pm_i.e.r;
    ie_p[1] <= pm_i.i.g * pm_i.e.g;
    ie_p[0] <= pm_i.i.b * pm_i.e.b;
    ee_p[2] <= pm_i.e.r * pm_i.e.r;
    ee_p[1] <= pm_i.e.g * pm_i.e.g;
    ee_p[0] <= pm_i.e.b * pm_i.e.b;
    ii_p[2] <= pm_i.i.r * pm_i.i.r;
    ii_p[1] <= pm_i.i.g * pm_i.i.g;
    ii_p[0] <= pm_i.i.b * pm_i.i.b;
    // Components of I x E
    cx_q    <= 17'(pm_i.i.g * pm_i.e.b) - 17'(pm_i.i.b * pm_i.e.g);
    cy_q    <= 17'(pm_i.i.b * pm_i.e.r) - 17'(pm_i.i.r * pm_i.e.b);
    cz_q    <= 17'(pm_i.i.r * pm_i.e.g) - 17'(pm_i.i.g * pm_i.e.r);
  end

  // Stage two, sums
  always_ff @(posedge clk_pixel) begin
    dt_o.xy     <= s1_q.xy;
    dt_o.i      <= s1_q.i;
    dt_o.e      <= s1_q.e;
    dt_o.ie     <= 18'(ie_p[2]) + 18'(ie_p[1]) + 18'(ie_p[0]);
    dt_o.ee     <= 18'(ee_p[2]) + 18'(ee_p[1]) + 18'(ee_p[0]);
    dt_o.ii     <= 18'(ii_p[2]) + 18'(ii_p[1]) + 18'(ii_p[0]);
    dt_o.cross2 <= 36'(cx_q * cx_q) + 36'(cy_q * cy_q) + 36'(cz_q * cz_q);
  end

endmodule

// ==== classify/pixel_classifier.sv ====
module pixel_classifier (
  input  logic                 clk_pixel,
  input  logic                 sys_rst_pixel,
  input  logic                 dt_valid_i,
  input  bgs_pkg::dist_terms_t dt_i,
  output logic                 cls_valid_o,
  output bgs_pkg::px_class_e   cls_o,
  output bgs_pkg::rgb565_t     cls_color_o,
  output bgs_pkg::coord_t      cls_xy_o,
  output bgs_pkg::rgb888_t     cls_pix_o,
  output bgs_pkg::rgb888_t     cls_est_o
);

  logic [43:0]        cd_lhs;
  logic [43:0]        cd_rhs;
  logic [23:0]        ie_x16;
  logic [23:0]        lo_lim;
  logic [23:0]        sh_lim;
  logic [23:0]        hl_lim;
  logic [23:0]        hi_lim;
  bgs_pkg::px_class_e cls_d;

  // Ratios compared by cross multiplication, no divider
  assign cd_lhs = {4'b0000, dt_i.cross2, 4'b0000};
  assign cd_rhs = 44'(bgs_pkg::CD_Q4) * 44'(dt_i.ii) * 44'(dt_i.ee);
  assign ie_x16 = {2'b00, dt_i.ie, 4'b0000};
  assign lo_lim = 24'(bgs_pkg::ALPHA_LO_Q4) * 24'(dt_i.ee);
  assign sh_lim = 24'(bgs_pkg::SHADOW_Q4) * 24'(dt_i.ee);
  assign hl_lim = 24'(bgs_pkg::HIGHLIGHT_Q4) * 24'(dt_i.ee);
  assign hi_lim = 24'(bgs_pkg::ALPHA_HI_Q4) * 24'(dt_i.ee);

  always_comb begin
    if (dt_i.ee == '0) begin  // Black model, only black matches
      cls_d = (dt_i.ii == '0) ? bgs_pkg::CLS_BG : bgs_pkg::CLS_FG;
    end else if (cd_lhs > cd_rhs) begin
      cls_d = bgs_pkg::CLS_FG;  // Hue moved
    end else if (ie_x16 >= sh_lim && ie_x16 <= hl_lim) begin
      cls_d = bgs_pkg::CLS_BG;
    end else if (ie_x16 >= lo_lim && ie_x16 < sh_lim) begin
      cls_d = bgs_pkg::CLS_SHADOW;
    end else if (ie_x16 > hl_lim && ie_x16 <= hi_lim) begin
      cls_d = bgs_pkg::CLS_HIGHLIGHT;
    end else begin
      cls_d = bgs_pkg::CLS_FG;
    end
  end

  always_ff @(posedge clk_pixel or posedge sys_rst_pixel) begin
    if (sys_rst_pixel) begin
      cls_valid_o <= 1'b0;
    end else begin
      cls_valid_o <= dt_valid_i;
    end
  end

  always_ff @(posedge clk_pixel) begin
    cls_o     <= cls_d;
    cls_xy_o  <= dt_i.xy;
    cls_pix_o <= dt_i.i;
    cls_est_o <= dt_i.e;
  end

  always_comb begin
    cls_color_o = bgs_pkg::COLOR_FG;
    case (cls_o)
      bgs_pkg::CLS_BG:        cls_color_o = bgs_pkg::COLOR_BG;
      bgs_pkg::CLS_FG:        cls_color_o = bgs_pkg::COLOR_FG;
      bgs_pkg::CLS_SHADOW:    cls_color_o = bgs_pkg::COLOR_SHADOW;
      bgs_pkg::CLS_HIGHLIGHT: cls_color_o = bgs_pkg::COLOR_HIGHLIGHT;
    endcase
  end

  a_cls_known: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
    cls_valid_o |-> !$isunknown(cls_o))
    else $error("cls_o unknown while valid: %h", cls_o);

endmodule

// ==== src/model_updater.sv ====
module model_updater (
  input  logic               clk_pixel,
  input  logic               sys_rst_pixel,
  input  logic               learn_i,
  input  logic               cls_valid_i,
  input  bgs_pkg::px_class_e cls_i,
  input  bgs_pkg::coord_t    cls_xy_i,
  input  bgs_pkg::rgb888_t   cls_pix_i,
  input  bgs_pkg::rgb888_t   cls_est_i,
  output mem_pkg::model_wr_t wr_o
);

  // E + ((I - E) >>> shift), floor rounding keeps it inside 0..255
  function automatic logic [7:0] avg_step(logic [7:0] pix, logic [7:0] est);
    logic signed [8:0] diff;
    logic signed [8:0] step;
    diff = $signed({1'b0, pix}) - $signed({1'b0, est});
    step = diff >>> bgs_pkg::LEARN_SHIFT;
    return est + step[7:0];
  endfunction

  always_comb begin
    // Detect mode only tracks pixels that still look like background
    wr_o.valid   = cls_valid_i && (learn_i || cls_i == bgs_pkg::CLS_BG);
    wr_o.addr    = mem_pkg::xy_to_addr(cls_xy_i);
    wr_o.entry.r = avg_step(cls_pix_i.r, cls_est_i.r);
    wr_o.entry.g = avg_step(cls_pix_i.g, cls_est_i.g);
    wr_o.entry.b = avg_step(cls_pix_i.b, cls_est_i.b);
  end

  // Input spacing carried through the pipe, the store relies on it
  a_wr_spacing: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
    wr_o.valid |=> !wr_o.valid)
    else $error("model writes in two adjacent cycles");

endmodule

// ==== src/fg_bbox.sv ====
module fg_bbox (
  input  logic               clk_pixel,
  input  logic               sys_rst_pixel,
  input  logic               cls_valid_i,
  input  bgs_pkg::px_class_e cls_i,
  input  bgs_pkg::coord_t    cls_xy_i,
  output logic               bbox_valid_o,
  output logic               bbox_found_o,
  output bgs_pkg::coord_t    bbox_min_o,
  output bgs_pkg::coord_t    bbox_max_o
);

  logic            is_fg;
  logic            is_last;
  logic            found_q;
  logic            found_next;
  bgs_pkg::coord_t min_q;
  bgs_pkg::coord_t max_q;
  bgs_pkg::coord_t min_next;
  bgs_pkg::coord_t max_next;

  assign is_fg      = cls_valid_i && (cls_i == bgs_pkg::CLS_FG);
  assign is_last    = cls_valid_i && (cls_xy_i.x == bgs_pkg::FRAME_W - 1)
                      && (cls_xy_i.y == bgs_pkg::FRAME_H - 1);
  assign found_next = found_q || is_fg;

  always_comb begin
    min_next = min_q;
    max_next = max_q;
    if (is_fg && !found_q) begin  // First hit seeds the box
      min_next = cls_xy_i;
      max_next = cls_xy_i;
    end else if (is_fg) begin
      if (cls_xy_i.x < min_q.x) min_next.x = cls_xy_i.x;
      if (cls_xy_i.y < min_q.y) min_next.y = cls_xy_i.y;
      if (cls_xy_i.x > max_q.x) max_next.x = cls_xy_i.x;
      if (cls_xy_i.y > max_q.y) max_next.y = cls_xy_i.y;
    end
  end

  always_ff @(posedge clk_pixel or posedge sys_rst_pixel) begin
    if (sys_rst_pixel) begin
      found_q      <= 1'b0;
      bbox_valid_o <= 1'b0;
      bbox_found_o <= 1'b0;
    end else begin
      bbox_valid_o <= is_last;
      if (is_last) begin
        bbox_found_o <= found_next;
        found_q      <= 1'b0;  // Fresh box next frame
      end else begin
        found_q <= found_next;
      end
    end
  end

  always_ff @(posedge clk_pixel) begin
    min_q <= min_next;
    max_q <= max_next;
    if (is_last) begin
      bbox_min_o <= min_next;
      bbox_max_o <= max_next;
    end
  end

endmodule

// ==== src/bgs_top.sv ====
module bgs_top (
  input  logic                 clk_pixel,
  input  logic                 sys_rst_pixel,
  input  logic                 pix_valid_i,
  input  bgs_pkg::rgb565_t     pix_i,
  input  bgs_pkg::coord_t      pix_xy_i,
  input  logic                 learn_i,
  output logic                 cls_valid_o,
  output bgs_pkg::px_class_e   cls_o,
  output bgs_pkg::rgb565_t     cls_color_o,
  output bgs_pkg::coord_t      cls_xy_o,
  output logic                 bbox_valid_o,
  output logic                 bbox_found_o,
  output bgs_pkg::coord_t      bbox_min_o,
  output bgs_pkg::coord_t      bbox_max_o
);

  logic                  rd_en;
  mem_pkg::model_addr_t  rd_addr;
  mem_pkg::model_entry_t rd_entry;
  mem_pkg::model_wr_t    model_wr;
  logic                  pm_valid;
  bgs_pkg::pix_model_t   pm;
  logic                  dt_valid;
  bgs_pkg::dist_terms_t  dt;
  bgs_pkg::rgb888_t      cls_pix;
  bgs_pkg::rgb888_t      cls_est;

  pixel_ingest ingest_i (
    .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel),
    .pix_valid_i(pix_valid_i), .pix_i(pix_i), .pix_xy_i(pix_xy_i),
    .rd_en_o(rd_en), .rd_addr_o(rd_addr), .rd_entry_i(rd_entry),
    .pm_valid_o(pm_valid), .pm_o(pm)
  );

  model_store store_i (
    .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel),
    .rd_en_i(rd_en), .rd_addr_i(rd_addr), .rd_entry_o(rd_entry),
    .wr_i(model_wr)
  );

  distortion_calc dist_i (
    .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel),
    .pm_valid_i(pm_valid), .pm_i(pm),
    .dt_valid_o(dt_valid), .dt_o(dt)
  );

  pixel_classifier classify_i (
    .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel),
    .dt_valid_i(dt_valid), .dt_i(dt),
    .cls_valid_o(cls_valid_o), .cls_o(cls_o), .cls_color_o(cls_color_o),
    .cls_xy_o(cls_xy_o), .cls_pix_o(cls_pix), .cls_est_o(cls_est)
  );

  model_updater updater_i (
    .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel),
    .learn_i(learn_i), .cls_valid_i(cls_valid_o), .cls_i(cls_o),
    .cls_xy_i(cls_xy_o), .cls_pix_i(cls_pix), .cls_est_i(cls_est),
    .wr_o(model_wr)
  );

  fg_bbox bbox_i (
    .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel),
    .cls_valid_i(cls_valid_o), .cls_i(cls_o), .cls_xy_i(cls_xy_o),
    .bbox_valid_o(bbox_valid_o), .bbox_found_o(bbox_found_o),
    .bbox_min_o(bbox_min_o), .bbox_max_o(bbox_max_o)
  );

endmodule

// ==== verif/tb_checks.sv ====
module tb_checks (
  input logic               clk_pixel,
  input logic               sys_rst_pixel,
  input logic               pix_valid_i,
  input bgs_pkg::rgb565_t   pix_i,
  input bgs_pkg::coord_t    pix_xy_i,
  input logic               learn_i,
  input logic [1:0]         expect_mode_i,  // 0 mirror only, 1 all background, 2 regions
  input logic               cls_valid_i,
  input bgs_pkg::px_class_e cls_i,
  input bgs_pkg::rgb565_t   cls_color_i,
  input bgs_pkg::coord_t    cls_xy_i,
  input logic               bbox_valid_i,
  input logic               bbox_found_i,
  input bgs_pkg::coord_t    bbox_min_i,
  input bgs_pkg::coord_t    bbox_max_i
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int LAT = 5;  // Sampling edges from input strobe to class output

  typedef struct packed {
    bgs_pkg::px_class_e cls;
    bgs_pkg::rgb565_t   color;
    bgs_pkg::coord_t    xy;
  } pred_t;

  bgs_pkg::rgb888_t mirror [bgs_pkg::FRAME_W * bgs_pkg::FRAME_H] = '{default: '0};
  pred_t            pipe [LAT] = '{default: '0};
  logic             found_acc = 1'b0;
  bgs_pkg::coord_t  min_acc;
  bgs_pkg::coord_t  max_acc;
  logic             exp_found = 1'b0;
  bgs_pkg::coord_t  exp_min;
  bgs_pkg::coord_t  exp_max;
  int               errors = 0;
  int               checks = 0;

  function automatic bgs_pkg::px_class_e rule_class(bgs_pkg::rgb888_t i, bgs_pkg::rgb888_t e);
    longint ie;
    longint ee;
    longint ii;
    longint cx;
    longint cy;
    longint cz;
    ie = longint'(i.r) * e.r + longint'(i.g) * e.g + longint'(i.b) * e.b;
    ee = longint'(e.r) * e.r + longint'(e.g) * e.g + longint'(e.b) * e.b;
    ii = longint'(i.r) * i.r + longint'(i.g) * i.g + longint'(i.b) * i.b;
    cx = longint'(i.g) * e.b - longint'(i.b) * e.g;
    cy = longint'(i.b) * e.r - longint'(i.r) * e.b;
    cz = longint'(i.r) * e.g - longint'(i.g) * e.r;
    if (ee == 0) return (ii == 0) ? bgs_pkg::CLS_BG : bgs_pkg::CLS_FG;
    if (16 * (cx * cx + cy * cy + cz * cz) > bgs_pkg::CD_Q4 * ii * ee) return bgs_pkg::CLS_FG;
    if (16 * ie < bgs_pkg::SHADOW_Q4 * ee) begin
      return (16 * ie >= bgs_pkg::ALPHA_LO_Q4 * ee) ? bgs_pkg::CLS_SHADOW : bgs_pkg::CLS_FG;
    end
    if (16 * ie <= bgs_pkg::HIGHLIGHT_Q4 * ee) return bgs_pkg::CLS_BG;
    return (16 * ie <= bgs_pkg::ALPHA_HI_Q4 * ee) ? bgs_pkg::CLS_HIGHLIGHT : bgs_pkg::CLS_FG;
  endfunction

  function automatic bgs_pkg::rgb565_t class_color(bgs_pkg::px_class_e c);
    case (c)
      bgs_pkg::CLS_BG:        return 16'h07E0;
      bgs_pkg::CLS_SHADOW:    return 16'h001F;
      bgs_pkg::CLS_HIGHLIGHT: return 16'hFFE0;
      default:                return 16'hF800;
    endcase
  endfunction

  // Running average with floor rounding of the quarter step
  function automatic logic [7:0] blend(logic [7:0] i, logic [7:0] e);
    int d;
    d = int'(i) - int'(e);
    return 8'(int'(e) + (d >>> bgs_pkg::LEARN_SHIFT));
  endfunction

  // Region layout of the test scene in the upper half
  function automatic bgs_pkg::px_class_e region_class(bgs_pkg::coord_t xy);
    if (xy.y >= 24) return bgs_pkg::CLS_BG;
    if (xy.x < 16) return bgs_pkg::CLS_SHADOW;
    if (xy.x < 32) return bgs_pkg::CLS_HIGHLIGHT;
    return bgs_pkg::CLS_FG;
  endfunction

  always @(posedge clk_pixel) begin : predict
    pred_t            p;
    bgs_pkg::rgb888_t i;
    bgs_pkg::rgb888_t e;
    int               a;
    int               k;
    p = '0;
    if (!sys_rst_pixel && pix_valid_i) begin
      a = int'(pix_xy_i.y) * bgs_pkg::FRAME_W + int'(pix_xy_i.x);
      i = {pix_i[15:11], 3'b000, pix_i[10:5], 2'b00, pix_i[4:0], 3'b000};
      e = mirror[a];
      p.cls = rule_class(i, e);
      p.color = class_color(p.cls);
      p.xy = pix_xy_i;
      if (learn_i || p.cls == bgs_pkg::CLS_BG) begin
        mirror[a] = {blend(i.r, e.r), blend(i.g, e.g), blend(i.b, e.b)};
      end
      if (p.cls == bgs_pkg::CLS_FG) begin
        if (!found_acc || pix_xy_i.x < min_acc.x) min_acc.x = pix_xy_i.x;
        if (!found_acc || pix_xy_i.y < min_acc.y) min_acc.y = pix_xy_i.y;
        if (!found_acc || pix_xy_i.x > max_acc.x) max_acc.x = pix_xy_i.x;
        if (!found_acc || pix_xy_i.y > max_acc.y) max_acc.y = pix_xy_i.y;
        found_acc = 1'b1;
      end
      if (a == bgs_pkg::FRAME_W * bgs_pkg::FRAME_H - 1) begin
        exp_found <= found_acc;
        exp_min   <= min_acc;
        exp_max   <= max_acc;
        found_acc = 1'b0;
      end
    end
    pipe[0] <= p;
    for (k = LAT - 1; k > 0; k--) pipe[k] <= pipe[k-1];
    if (!sys_rst_pixel && (cls_valid_i || bbox_valid_i)) checks++;
  end

  a_reset_quiet: assert property (@(posedge clk_pixel)
    (sys_rst_pixel || $past(sys_rst_pixel)) |-> !cls_valid_i && !bbox_valid_i)
    else begin
      errors++;
      $display("valid output raised during or right after reset");
    end

  a_latency_rise: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
    pix_valid_i |-> ##LAT cls_valid_i)
    else begin
      errors++;
      $display("cls_valid_o did not rise the expected latency after pix_valid_i");
    end

  a_latency_src: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
    cls_valid_i |-> $past(pix_valid_i, LAT))
    else begin
      errors++;
      $display("cls_valid_o high without a pix_valid_i the expected latency before");
    end

  a_result: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
    cls_valid_i |-> {cls_i, cls_color_i, cls_xy_i} == pipe[LAT-1])
    else begin
      errors++;
      $display("mismatch cls_o %h exp %h cls_color_o %h exp %h cls_xy_o %h exp %h",
               $sampled(cls_i), $sampled(pipe[LAT-1].cls), $sampled(cls_color_i),
               $sampled(pipe[LAT-1].color), $sampled(cls_xy_i),
               $sampled(pipe[LAT-1].xy));
    end

  a_scene: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
    cls_valid_i && expect_mode_i != 0 |->
      cls_i == ((expect_mode_i == 1) ? bgs_pkg::CLS_BG : region_class(cls_xy_i)))
    else begin
      errors++;
      $display("mismatch cls_o %h exp %h against scene layout at xy %h",
               $sampled(cls_i),
               ($sampled(expect_mode_i) == 1) ? bgs_pkg::CLS_BG
                                              : region_class($sampled(cls_xy_i)),
               $sampled(cls_xy_i));
    end

  a_bbox_timing: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
    bbox_valid_i == $past(cls_valid_i && cls_xy_i == {6'd63, 6'd47}))
    else begin
      errors++;
      $display("bbox_valid_o not one cycle after the last pixel of the frame");
    end

  a_bbox_box: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
    bbox_valid_i |-> bbox_found_i == exp_found
      && (!exp_found || (bbox_min_i == exp_min && bbox_max_i == exp_max)))
    else begin
      errors++;
      $display("mismatch bbox_found_o %h exp %h bbox_min_o %h exp %h bbox_max_o %h exp %h",
               $sampled(bbox_found_i), exp_found, $sampled(bbox_min_i), exp_min,
               $sampled(bbox_max_i), exp_max);
    end

endmodule

// ==== verif/tb_top.sv ====
module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int  LEARN_FRAMES = 14;
  localparam int  FRAMES       = LEARN_FRAMES + 3;
  localparam real WATCHDOG_NS  = real'(FRAMES * bgs_pkg::FRAME_W * bgs_pkg::FRAME_H * 2 * 10)
                                 + 20000.0;

  logic               clk_pixel = 1'b0;
  logic               sys_rst_pixel = 1'b1;
  logic               pix_valid = 1'b0;
  bgs_pkg::rgb565_t   pix = '0;
  bgs_pkg::coord_t    pix_xy = '0;
  logic               learn = 1'b1;
  logic [1:0]         expect_mode = 2'd0;
  logic               cls_valid;
  bgs_pkg::px_class_e cls;
  bgs_pkg::rgb565_t   cls_color;
  bgs_pkg::coord_t    cls_xy;
  logic               bbox_valid;
  logic               bbox_found;
  bgs_pkg::coord_t    bbox_min;
  bgs_pkg::coord_t    bbox_max;
  logic [31:0]        lfsr = 32'hae876f48;

  initial forever #5 clk_pixel = ~clk_pixel;

  bgs_top dut_i (
    .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel),
    .pix_valid_i(pix_valid), .pix_i(pix), .pix_xy_i(pix_xy), .learn_i(learn),
    .cls_valid_o(cls_valid), .cls_o(cls), .cls_color_o(cls_color), .cls_xy_o(cls_xy),
    .bbox_valid_o(bbox_valid), .bbox_found_o(bbox_found),
    .bbox_min_o(bbox_min), .bbox_max_o(bbox_max)
  );

  tb_checks checks_i (
    .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel),
    .pix_valid_i(pix_valid), .pix_i(pix), .pix_xy_i(pix_xy), .learn_i(learn),
    .expect_mode_i(expect_mode),
    .cls_valid_i(cls_valid), .cls_i(cls), .cls_color_i(cls_color), .cls_xy_i(cls_xy),
    .bbox_valid_i(bbox_valid), .bbox_found_i(bbox_found),
    .bbox_min_i(bbox_min), .bbox_max_i(bbox_max)
  );

  // Galois LFSR, one step per bit
  function automatic logic take_bit();
    logic b;
    b = lfsr[0];
    lfsr = (lfsr >> 1) ^ (b ? 32'h80200003 : 32'h0);
    return b;
  endfunction

  // Gentle gradient, kind 2 alters the upper half in four column bands
  function automatic bgs_pkg::rgb565_t scene_px(bgs_pkg::coord_t xy, int kind, logic nz);
    int r;
    int g;
    int b;
    r = 6 + int'(xy.x) / 8;
    g = 12 + int'(xy.y) / 8 + int'(nz);  // Noise only in green LSB
    b = 6 + (int'(xy.x) + int'(xy.y)) / 16;
    if (kind == 2 && xy.y < 24) begin
      if (xy.x < 16) begin
        r = r * 3 / 4;
        g = g * 3 / 4;
        b = b * 3 / 4;
      end else if (xy.x < 32) begin
        r = r * 5 / 4;
        g = g * 5 / 4;
        b = b * 5 / 4;
      end else if (xy.x < 48) begin
        r = r * 2;
        g = g * 2;
        b = b * 2;
      end else begin
        r = 0;
        g = 0;
        b = 31;
      end
    end
    return {5'(r), 6'(g), 5'(b)};
  endfunction

  task automatic run_frame(string name, int kind, logic learn_mode, logic noisy);
    bgs_pkg::coord_t xy;
    int              errs_before;
    errs_before = checks_i.errors;
    @(negedge clk_pixel);
    learn = learn_mode;
    expect_mode = learn_mode ? 2'd0 : ((kind == 2) ? 2'd2 : 2'd1);
    for (int y = 0; y < bgs_pkg::FRAME_H; y++) begin
      for (int x = 0; x < bgs_pkg::FRAME_W; x++) begin
        xy.x = 6'(x);
        xy.y = 6'(y);
        @(negedge clk_pixel);
        pix_valid = 1'b1;
        pix = scene_px(xy, kind, noisy ? take_bit() : 1'b0);
        pix_xy = xy;
        @(negedge clk_pixel);
        pix_valid = 1'b0;
      end
    end
    repeat (12) @(negedge clk_pixel);  // Drain pipe and box report
    $display("test %s: %0d errors", name, checks_i.errors - errs_before);
  endtask

  initial begin
    repeat (2) @(posedge clk_pixel);
    @(negedge clk_pixel);
    sys_rst_pixel = 1'b0;
    repeat (4) @(negedge clk_pixel);
    $display("test reset: %0d errors", checks_i.errors);
    for (int f = 0; f < LEARN_FRAMES; f++) begin
      run_frame($sformatf("learn_%0d", f), 0, 1'b1, 1'b1);
    end
    run_frame("detect_static", 0, 1'b0, 1'b0);
    run_frame("detect_regions", 2, 1'b0, 1'b0);
    run_frame("detect_after_regions", 0, 1'b0, 1'b0);
    $display("checks %0d errors %0d", checks_i.checks, checks_i.errors);
    if (checks_i.errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within the expected time");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== flist.f ====
common/bgs_pkg.sv
common/mem_pkg.sv
src/pixel_ingest.sv
model/model_store.sv
classify/distortion_calc.sv
classify/pixel_classifier.sv
src/model_updater.sv
src/fg_bbox.sv
src/bgs_top.sv
verif/tb_checks.sv
verif/tb_top.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
